// ==== sources.f ====
src/rv_pkg.sv
src/rv_rf_if.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_ras.sv
src/rv_exec_ctrl.sv
src/rv_exec_top.sv
testbench/tb_rv_exec.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rv_exec -f sources.f || exit 1
out="$(./obj_dir/Vtb_rv_exec 2>&1)"
echo "$out"
grep -qxF ">>> PASS" <<< "$out" && exit 0 || exit 1

// ==== testbench/tb_rv_exec.sv ====
`default_nettype none

module tb_rv_exec;

  localparam int          CLK_PERIOD       = 20;
  localparam int          N_INSTR          = 400;
  localparam int          CYCLES_PER_INSTR = 40;
  localparam logic [31:0] START_PC         = 32'h0000_1000;
  localparam logic [31:0] FIRST_JAL        = 32'h0400_00ef; // jal x1, +64

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] value;
    logic        redirect;
    logic [31:0] target;
    logic        mem;
    logic        write;
    logic [2:0]  size;
    logic [31:0] store_data;
    logic        ret;
    logic        pred_hit;
  } rec_t;

  typedef struct packed {
    rec_t rec;
    logic cti;
    logic value_dc; // Value field carries no defined result
  } exp_t;

  logic        clk_i       = 1'b0;
  logic        rst_i       = 1'b1;
  logic        in_valid_i  = 1'b0;
  logic [31:0] in_instr_i  = 32'h0;
  logic [31:0] in_pc_i     = 32'h0;
  logic        res_ready_i = 1'b0;
  logic        in_ready_o;
  logic        res_valid_o;
  logic [4:0]  res_rd_o;
  logic [31:0] res_value_o;
  logic        res_redirect_o;
  logic [31:0] res_target_o;
  logic        res_mem_o;
  logic        res_write_o;
  logic [2:0]  res_size_o;
  logic [31:0] res_store_data_o;
  logic        res_return_o;
  logic        res_pred_hit_o;

  logic [31:0] lfsr        = 32'hba36;
  logic [31:0] model_pc    = START_PC;
  logic [31:0] regs [32];
  logic [31:0] ras_q [$];   // Model return stack with the newest at the back
  exp_t        exp_q [$];
  logic        pending_in  = 1'b0;
  logic        cti_pending = 1'b0;
  logic        prev_hold   = 1'b0;
  rec_t        held;
  int          cycle       = 0;
  int          n_gen       = 0;
  int          n_done      = 0;
  int          drain       = 0;

  rv_exec_top #(.XLEN(32), .RAS_DEPTH(4)) u_rv_exec_top (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .in_instr_i       (in_instr_i),
    .in_pc_i          (in_pc_i),
    .res_valid_o      (res_valid_o),
    .res_ready_i      (res_ready_i),
    .res_rd_o         (res_rd_o),
    .res_value_o      (res_value_o),
    .res_redirect_o   (res_redirect_o),
    .res_target_o     (res_target_o),
    .res_mem_o        (res_mem_o),
    .res_write_o      (res_write_o),
    .res_size_o       (res_size_o),
    .res_store_data_o (res_store_data_o),
    .res_return_o     (res_return_o),
    .res_pred_hit_o   (res_pred_hit_o)
  );

  initial
  begin
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  initial
  begin
    #(N_INSTR * CYCLES_PER_INSTR * CLK_PERIOD);
    $display("Timeout with %0d of %0d results received", n_done, N_INSTR);
    $display(">>> FAIL");
    $fatal(1);
  end

  // Galois LFSR stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = 32'h0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [4:0] pick_reg();
    logic [3:0] v;
    v = 4'(rand_bits(4));
    if (v[3])
      return v[0] ? 5'd1 : 5'd5; // Link registers favoured
    else if (v == 4'd0)
      return 5'd2;
    else
      return {2'b00, v[2:0]};
  endfunction

  function automatic logic [31:0] gen_instr();
    logic [3:0]  cls;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [8:0]  o9;
    logic [31:0] off;
    cls   = 4'(rand_bits(4));
    rd    = pick_reg();
    rs1   = pick_reg();
    rs2   = pick_reg();
    f3    = 3'(rand_bits(3));
    imm12 = 12'(rand_bits(12));
    o9    = 9'(rand_bits(9));
    off   = {{21{o9[8]}}, o9, 2'b00}; // Word offset of about +-1 KiB
    case (cls)
      4'd0, 4'd1, 4'd2, 4'd3:
      begin
        if (f3 == 3'd1)
          imm12[11:5] = 7'b0;
        else if (f3 == 3'd5)
          imm12[11:5] = {1'b0, imm12[10], 5'b0}; // SRLI or SRAI
        return {imm12, rs1, f3, rd, 7'h13};
      end
      4'd4, 4'd5:
        return {((f3 == 3'd0 || f3 == 3'd5) && imm12[0]) ? 7'h20 : 7'h00,
                rs2, rs1, f3, rd, 7'h33};
      4'd6:    return {20'(rand_bits(20)), rd, 7'h37};
      4'd7:    return {20'(rand_bits(20)), rd, 7'h17};
      4'd8:    return {imm12, rs1, f3, rd, 7'h03};
      4'd9:    return {imm12[11:5], rs2, rs1, 1'b0, f3[1:0], imm12[4:0], 7'h23};
      4'd10, 4'd11:
      begin
        if (f3[2:1] == 2'b01)
          f3[1] = 1'b0;
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
      end
      4'd12:   return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
      4'd13, 4'd14:
      begin
        case (2'(rand_bits(2)))
          2'd0:    rd = 5'd0;
          2'd1:    rd = 5'd1;
          2'd2:    rd = 5'd5;
          default: ;
        endcase
        if (imm12[11])
          imm12 = 12'h0; // Plain return half the time
        return {imm12, rs1, 3'b000, rd, 7'h67};
      end
      default: return {25'(rand_bits(25)), 7'h0f}; // Unsupported FENCE
    endcase
  endfunction

  function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:
      begin
        if (alt)
          return $signed(a) >>> b[4:0];
        else
          return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic rec_t observed();
    rec_t r;
    r.rd         = res_rd_o;
    r.value      = res_value_o;
    r.redirect   = res_redirect_o;
    r.target     = res_target_o;
    r.mem        = res_mem_o;
    r.write      = res_write_o;
    r.size       = res_size_o;
    r.store_data = res_store_data_o;
    r.ret        = res_return_o;
    r.pred_hit   = res_pred_hit_o;
    return r;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want)
    else
    begin
      $display("FAIL %s got %h expected %h", name, got, want);
      stop_run("Result does not match the reference model");
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < 32; i++)
      regs[i] = 32'h0;
    ras_q.delete();
    exp_q.delete();
  endtask

  // Reference model step for the instruction taken on this edge
  task automatic accept_input();
    exp_t        x;
    logic [31:0] ins;
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] pred;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic        rd_link;
    logic        push;
    logic        pop;
    assert (!cti_pending)
    else stop_run("Input accepted while a control transfer was in flight");
    ins     = in_instr_i;
    pc      = in_pc_i;
    f3      = ins[14:12];
    rd      = ins[11:7];
    rs1     = ins[19:15];
    a       = regs[rs1];
    b       = regs[ins[24:20]];
    imm_i   = {{20{ins[31]}}, ins[31:20]};
    rd_link = (rd == 5'd1) || (rd == 5'd5);
    push    = 1'b0;
    pop     = 1'b0;
    x       = '0;
    case (ins[6:0])
      7'h13:
      begin
        x.rec.rd    = rd;
        x.rec.value = alu_result(f3, ins[30] && (f3 == 3'd5), a, imm_i);
      end
      7'h33:
      begin
        x.rec.rd    = rd;
        x.rec.value = alu_result(f3, ins[30], a, b);
      end
      7'h37:
      begin
        x.rec.rd    = rd;
        x.rec.value = {ins[31:12], 12'b0};
      end
      7'h17:
      begin
        x.rec.rd    = rd;
        x.rec.value = pc + {ins[31:12], 12'b0};
      end
      7'h03:
      begin
        x.rec.rd    = rd; // Request only without write-back
        x.rec.value = a + imm_i;
        x.rec.mem   = 1'b1;
        x.rec.size  = f3;
      end
      7'h23:
      begin
        x.rec.value      = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        x.rec.mem        = 1'b1;
        x.rec.write      = 1'b1;
        x.rec.size       = f3;
        x.rec.store_data = b;
      end
      7'h63:
      begin
        x.rec.target   = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        x.rec.redirect = branch_taken(f3, a, b);
        x.cti          = 1'b1;
        x.value_dc     = 1'b1;
      end
      7'h6f:
      begin
        x.rec.rd       = rd;
        x.rec.value    = pc + 32'd4;
        x.rec.target   = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        x.rec.redirect = 1'b1;
        x.cti          = 1'b1;
        push           = rd_link;
      end
      7'h67:
      begin
        x.rec.rd       = rd;
        x.rec.value    = pc + 32'd4;
        x.rec.target   = (a + imm_i) & ~32'h1;
        x.rec.redirect = 1'b1;
        x.cti          = 1'b1;
        push           = rd_link;
        pop            = ((rs1 == 5'd1) || (rs1 == 5'd5)) && !(rd_link && (rd == rs1));
      end
      default: x.value_dc = 1'b1;
    endcase
    pred            = (ras_q.size() == 0) ? 32'h0 : ras_q[$];
    x.rec.ret       = pop;
    x.rec.pred_hit  = pop && (pred == x.rec.target);
    if (pop && ras_q.size() != 0)
      void'(ras_q.pop_back());
    if (push)
    begin
      ras_q.push_back(pc + 32'd4);
      if (ras_q.size() > 4)
        void'(ras_q.pop_front()); // Oldest entry lost
    end
    if (x.rec.rd != 5'd0 && !x.rec.mem)
      regs[x.rec.rd] = x.rec.value;
    model_pc    = x.rec.redirect ? x.rec.target : pc + 32'd4;
    cti_pending = cti_pending | x.cti;
    pending_in  = 1'b0;
    exp_q.push_back(x);
  endtask

  task automatic check_result();
    exp_t x;
    assert (exp_q.size() != 0)
    else stop_run("Result appeared with no instruction outstanding");
    x = exp_q.pop_front();
    check_field("res_rd_o", 32'(res_rd_o), 32'(x.rec.rd));
    if (!x.value_dc)
      check_field("res_value_o", res_value_o, x.rec.value);
    check_field("res_redirect_o", 32'(res_redirect_o), 32'(x.rec.redirect));
    if (x.rec.redirect)
      check_field("res_target_o", res_target_o, x.rec.target);
    check_field("res_mem_o", 32'(res_mem_o), 32'(x.rec.mem));
    check_field("res_write_o", 32'(res_write_o), 32'(x.rec.write));
    if (x.rec.mem)
      check_field("res_size_o", 32'(res_size_o), 32'(x.rec.size));
    if (x.rec.write)
      check_field("res_store_data_o", res_store_data_o, x.rec.store_data);
    check_field("res_return_o", 32'(res_return_o), 32'(x.rec.ret));
    check_field("res_pred_hit_o", 32'(res_pred_hit_o), 32'(x.rec.pred_hit));
    if (n_done == 0)
      check_field("res_value_o", res_value_o, START_PC + 32'd4); // Link of first JAL
    if (x.cti)
      cti_pending = 1'b0;
    n_done++;
  endtask

  task automatic check_hold();
    if (prev_hold)
    begin
      assert (res_valid_o)
      else stop_run("res_valid_o dropped before the result was accepted");
      assert (observed() === held)
      else
      begin
        $display("FAIL result fields %h held %h", observed(), held);
        stop_run("Result changed under back-pressure");
      end
    end
    prev_hold = res_valid_o && !res_ready_i;
    held      = observed();
  endtask

  task automatic drive_inputs();
    if (!pending_in)
    begin
      if (n_gen < N_INSTR && rand_bits(3) != 32'd0)
      begin
        in_instr_i <= (n_gen == 0) ? FIRST_JAL : gen_instr();
        in_pc_i    <= model_pc;
        in_valid_i <= 1'b1;
        pending_in = 1'b1;
        n_gen++;
      end
      else
        in_valid_i <= 1'b0;
    end
    res_ready_i <= (rand_bits(2) != 32'd0); // Stalls about a quarter of cycles
  endtask

  task automatic finish_run();
    drain++;
    if (drain > 1)
    begin
      assert (!res_valid_o)
      else stop_run("Extra result after the last instruction");
    end
    if (drain == 5)
    begin
      $display(">>> PASS");
      $finish;
    end
  endtask

  // Samples see pre-edge values while new inputs land after the edge
  always @(posedge clk_i)
  begin
    cycle++;
    if (cycle == 1)
      clear_model();
    else if (cycle == 2)
      rst_i <= 1'b0;
    else
    begin
      if (cycle == 3)
      begin
        assert (!res_valid_o && in_ready_o)
        else stop_run("DUT outputs not idle after reset");
      end
      if (in_valid_i && in_ready_o)
        accept_input();
      if (res_valid_o && res_ready_i)
        check_result();
      check_hold();
      if (n_done < N_INSTR)
        drive_inputs();
      else
        finish_run();
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_exec_top.sv ====
`default_nettype none

module rv_exec_top #(
  parameter int XLEN      = rv_pkg::XLEN_DEFAULT,
  parameter int RAS_DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  logic [31:0]                 in_instr_i,
  input  logic [XLEN-1:0]             in_pc_i,
  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output logic [rv_pkg::REG_BITS-1:0] res_rd_o,
  output logic [XLEN-1:0]             res_value_o,
  output logic                        res_redirect_o,
  output logic [XLEN-1:0]             res_target_o,
  output logic                        res_mem_o,
  output logic                        res_write_o,
  output logic [2:0]                  res_size_o,
  output logic [XLEN-1:0]             res_store_data_o,
  output logic                        res_return_o,
  output logic                        res_pred_hit_o
);

  rv_pkg::decoded_t dec;
  rv_pkg::decoded_t alu_ex;
  rv_pkg::result_t  alu_res;
  rv_pkg::result_t  res;
  logic             dec_load;
  logic             ras_push;
  logic             ras_pop;
  logic [XLEN-1:0]  ras_top;
  logic [XLEN-1:0]  ex_ras_top;
  logic [XLEN-1:0]  alu_rs1;
  logic [XLEN-1:0]  alu_rs2;

  rv_rf_if #(.XLEN(XLEN)) u_rf_if ();

  rv_decode #(.XLEN(XLEN)) u_rv_decode (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .instr_i (in_instr_i),
    .pc_i    (in_pc_i),
    .load_i  (dec_load),
    .dec_o   (dec),
    .push_o  (ras_push),
    .pop_o   (ras_pop)
  );

  rv_regfile #(.XLEN(XLEN)) u_rv_regfile (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .rf    (u_rf_if.regfile)
  );

  // Pushed link is pc+4 of the instruction being loaded
  rv_ras #(.XLEN(XLEN), .RAS_DEPTH(RAS_DEPTH)) u_rv_ras (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .push_i      (ras_push),
    .pop_i       (ras_pop),
    .push_data_i (in_pc_i + XLEN'(4)),
    .top_o       (ras_top)
  );

  rv_alu #(.XLEN(XLEN)) u_rv_alu (
    .ex_i       (alu_ex),
    .rs1_data_i (alu_rs1),
    .rs2_data_i (alu_rs2),
    .ras_top_i  (ex_ras_top),
    .res_o      (alu_res)
  );

  rv_exec_ctrl #(.XLEN(XLEN)) u_rv_exec_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .dec_i       (dec),
    .dec_load_o  (dec_load),
    .ras_top_i   (ras_top),
    .ras_top_o   (ex_ras_top),
    .rf          (u_rf_if.ctrl),
    .alu_ex_o    (alu_ex),
    .alu_rs1_o   (alu_rs1),
    .alu_rs2_o   (alu_rs2),
    .alu_res_i   (alu_res),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_o       (res)
  );

  assign res_rd_o         = res.rd;
  assign res_value_o      = res.value;
  assign res_redirect_o   = res.redirect;
  assign res_target_o     = res.target;
  assign res_mem_o        = res.mem;
  assign res_write_o      = res.write;
  assign res_size_o       = res.size;
  assign res_store_data_o = res.store_data;
  assign res_return_o     = res.ret;
  assign res_pred_hit_o   = res.pred_hit;

endmodule

`default_nettype wire

// ==== src/rv_exec_ctrl.sv ====
`default_nettype none

module rv_exec_ctrl #(
  parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  rv_pkg::decoded_t dec_i,
  output logic             dec_load_o,
  input  logic [XLEN-1:0]  ras_top_i,
  output logic [XLEN-1:0]  ras_top_o,
  rv_rf_if.ctrl            rf,
  output rv_pkg::decoded_t alu_ex_o,
  output logic [XLEN-1:0]  alu_rs1_o,
  output logic [XLEN-1:0]  alu_rs2_o,
  input  rv_pkg::result_t  alu_res_i,
  output logic             res_valid_o,
  input  logic             res_ready_i,
  output rv_pkg::result_t  res_o
);

  logic            dec_valid;
  logic            ex_valid;
  logic            cti_busy;  // Control transfer past decode
  logic [XLEN-1:0] dec_top;   // Stack top seen when decode loaded
  logic            out_hs;
  logic            ex_adv;
  logic            dec_adv;
  logic            dec_cti;
  logic            hazard;

  // Older instruction whose register result is not yet in the regfile
  function automatic logic raw(input logic [rv_pkg::REG_BITS-1:0] rd, input logic mem,
                               input rv_pkg::decoded_t d);
    return (rd != '0) & ~mem & ((rd == d.rs1) | (rd == d.rs2));
  endfunction

  assign out_hs  = res_valid_o & res_ready_i;
  assign ex_adv  = ex_valid & (~res_valid_o | res_ready_i);
  assign dec_cti = dec_i.branch | dec_i.jal | dec_i.jalr;
  assign hazard  = (ex_valid & raw(alu_ex_o.rd, alu_ex_o.mem, dec_i))
                 | (res_valid_o & ~res_ready_i & raw(res_o.rd, res_o.mem, dec_i));
  assign dec_adv = dec_valid & (~ex_valid | ex_adv) & ~hazard;

  assign in_ready_o = ~cti_busy & ~(dec_valid & dec_cti) & (~dec_valid | dec_adv);
  assign dec_load_o = in_valid_i & in_ready_o;

  assign rf.rs1_addr = dec_i.rs1;
  assign rf.rs2_addr = dec_i.rs2;
  assign rf.we       = out_hs & (res_o.rd != '0) & ~res_o.mem; // Loads only request
  assign rf.waddr    = res_o.rd;
  assign rf.wdata    = res_o.value;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      dec_valid   <= 1'b0;
      ex_valid    <= 1'b0;
      res_valid_o <= 1'b0;
      cti_busy    <= 1'b0;
    end
    else
    begin
      dec_valid   <= dec_load_o | (dec_valid & ~dec_adv);
      ex_valid    <= dec_adv | (ex_valid & ~ex_adv);
      res_valid_o <= ex_adv | (res_valid_o & ~res_ready_i);
      if (dec_adv & dec_cti)
        cti_busy <= 1'b1;
      else if (out_hs & ~ex_valid) // Transfer is the youngest, so it is leaving
        cti_busy <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (dec_load_o)
      dec_top <= ras_top_i;
    if (dec_adv)
    begin
      alu_ex_o  <= dec_i;
      alu_rs1_o <= rf.rs1_data;
      alu_rs2_o <= rf.rs2_data;
      ras_top_o <= dec_top;
    end
    if (ex_adv)
      res_o <= alu_res_i;
  end

endmodule

`default_nettype wire

// ==== src/rv_ras.sv ====
`default_nettype none

module rv_ras #(
  parameter int XLEN      = rv_pkg::XLEN_DEFAULT,
  parameter int RAS_DEPTH = 4
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            push_i,
  input  logic            pop_i,
  input  logic [XLEN-1:0] push_data_i,
  output logic [XLEN-1:0] top_o
);

  localparam int PTR_BITS = $clog2(RAS_DEPTH);

  logic [XLEN-1:0]     stack [RAS_DEPTH];
  logic [PTR_BITS-1:0] ptr;   // Points at the top entry
  logic [PTR_BITS:0]   count;
  logic                pop_ok;

  assign pop_ok = pop_i & (count != '0); // Pop of an empty stack is ignored
  assign top_o  = (count == '0) ? '0 : stack[ptr];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ptr   <= '0;
      count <= '0;
    end
    else
    begin
      case ({push_i, pop_ok})
        2'b11: stack[ptr] <= push_data_i; // Pop then push, replace top
        2'b10:
        begin
          stack[ptr + 1'b1] <= push_data_i;
          ptr               <= ptr + 1'b1;
          if (count != (PTR_BITS+1)'(RAS_DEPTH)) // Full wraps over oldest
            count <= count + 1'b1;
        end
        2'b01:
        begin
          ptr   <= ptr - 1'b1;
          count <= count - 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_alu.sv ====
`default_nettype none

module rv_alu #(
  parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
  input  rv_pkg::decoded_t  ex_i,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  input  logic [XLEN-1:0]   ras_top_i,
  output rv_pkg::result_t   res_o
);

  localparam int SHW = $clog2(XLEN);

  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] target;
  logic [SHW-1:0]  shamt;
  logic            taken;

  assign op2   = ex_i.imm_valid ? ex_i.imm : rs2_data_i;
  assign shamt = op2[SHW-1:0];

  always_comb
  begin
    case (ex_i.alu_op)
      rv_pkg::ALU_ADD:  alu_out = rs1_data_i + op2;
      rv_pkg::ALU_SUB:  alu_out = rs1_data_i - op2;
      rv_pkg::ALU_SLL:  alu_out = rs1_data_i << shamt;
      rv_pkg::ALU_SRL:  alu_out = rs1_data_i >> shamt;
      rv_pkg::ALU_SRA:  alu_out = $signed(rs1_data_i) >>> shamt;
      rv_pkg::ALU_SLT:  alu_out = XLEN'($signed(rs1_data_i) < $signed(op2));
      rv_pkg::ALU_SLTU: alu_out = XLEN'(rs1_data_i < op2);
      rv_pkg::ALU_XOR:  alu_out = rs1_data_i ^ op2;
      rv_pkg::ALU_OR:   alu_out = rs1_data_i | op2;
      rv_pkg::ALU_AND:  alu_out = rs1_data_i & op2;
      default:          alu_out = '0;
    endcase
  end

  // Branch compare on rs1 and rs2, funct3 encoding
  always_comb
  begin
    case (ex_i.br_cond)
      3'b000:  taken = rs1_data_i == rs2_data_i;
      3'b001:  taken = rs1_data_i != rs2_data_i;
      3'b100:  taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      3'b101:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      3'b110:  taken = rs1_data_i < rs2_data_i;
      3'b111:  taken = rs1_data_i >= rs2_data_i;
      default: taken = 1'b0;
    endcase
  end

  always_comb
  begin
    if (ex_i.jal)
      target = ex_i.jal_target;
    else if (ex_i.jalr)
      target = {alu_out[XLEN-1:1], 1'b0}; // rs1 + imm, bit 0 cleared
    else if (ex_i.branch)
      target = ex_i.pc + ex_i.imm;
    else
      target = '0;
  end

  assign res_o.rd         = ex_i.rd;
  assign res_o.value      = ex_i.link ? ex_i.link_val : alu_out;
  assign res_o.redirect   = ex_i.jal | ex_i.jalr | (ex_i.branch & taken);
  assign res_o.target     = target;
  assign res_o.mem        = ex_i.mem;
  assign res_o.write      = ex_i.mem_write;
  assign res_o.size       = ex_i.size;
  assign res_o.store_data = rs2_data_i;
  assign res_o.ret        = ex_i.ret;
  assign res_o.pred_hit   = ex_i.ret & (ras_top_i == target);

endmodule

`default_nettype wire

// ==== src/rv_regfile.sv ====
`default_nettype none

module rv_regfile #(
  parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
  input  logic       clk_i,
  input  logic       rst_i,
  rv_rf_if.regfile   rf
);

  logic [XLEN-1:0] regs [32];
  logic            wr_en;

  assign wr_en = rf.we & (rf.waddr != '0); // x0 stays zero

  // Write-through so a same-cycle read sees the new value
  assign rf.rs1_data = (wr_en & (rf.waddr == rf.rs1_addr)) ? rf.wdata : regs[rf.rs1_addr];
  assign rf.rs2_data = (wr_en & (rf.waddr == rf.rs2_addr)) ? rf.wdata : regs[rf.rs2_addr];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr_en)
      regs[rf.waddr] <= rf.wdata;
  end

endmodule

`default_nettype wire

// ==== src/rv_decode.sv ====
`default_nettype none

module rv_decode #(
  parameter int XLEN = rv_pkg::XLEN_DEFAULT
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [31:0]         instr_i,
  input  logic [XLEN-1:0]     pc_i,
  input  logic                load_i,
  output rv_pkg::decoded_t    dec_o,
  output logic                push_o,
  output logic                pop_o
);

  localparam logic [rv_pkg::REG_BITS-1:0] LINK_RA = 5'd1;
  localparam logic [rv_pkg::REG_BITS-1:0] LINK_T0 = 5'd5; // Alternate link

  logic [4:0]                  opcode;
  logic [2:0]                  funct3;
  logic [rv_pkg::REG_BITS-1:0] rd;
  logic [rv_pkg::REG_BITS-1:0] rs1;
  logic [rv_pkg::REG_BITS-1:0] rs2;
  logic [XLEN-1:0]             imm_i;
  logic [XLEN-1:0]             imm_s;
  logic [XLEN-1:0]             imm_b;
  logic [XLEN-1:0]             imm_u;
  logic [XLEN-1:0]             imm_j;
  logic [XLEN-1:0]             link_val;
  logic [XLEN-1:0]             jal_target;
  logic [XLEN-1:0]             auipc_sum;
  logic                        rd_link;
  logic                        rs1_link;
  logic                        push_c;
  logic                        pop_c;
  rv_pkg::enc_e                enc;
  rv_pkg::decoded_t            dec_d;

  assign opcode = instr_i[6:2];
  assign funct3 = instr_i[14:12];
  assign rd     = instr_i[11:7];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];

  assign imm_i = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{(XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{(XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                  instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_u = XLEN'($signed({instr_i[31:12], 12'b0}));
  assign imm_j = {{(XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                  instr_i[20], instr_i[30:21], 1'b0};

  assign link_val   = pc_i + XLEN'(4);
  assign jal_target = pc_i + imm_j;
  assign auipc_sum  = pc_i + imm_u;

  // Link register rules, rd == rs1 on a linking JALR is push only
  assign rd_link  = (rd == LINK_RA) | (rd == LINK_T0);
  assign rs1_link = (rs1 == LINK_RA) | (rs1 == LINK_T0);
  assign push_c   = rd_link & ((opcode == rv_pkg::JAL) | (opcode == rv_pkg::JALR));
  assign pop_c    = rs1_link & (opcode == rv_pkg::JALR) & ~(push_c & (rd == rs1));
  assign push_o   = load_i & push_c;
  assign pop_o    = load_i & pop_c;

  always_comb
  begin
    case (opcode)
      rv_pkg::LOAD,
      rv_pkg::OP_IMM,
      rv_pkg::JALR:   enc = rv_pkg::ENC_I;
      rv_pkg::AUIPC,
      rv_pkg::LUI:    enc = rv_pkg::ENC_U;
      rv_pkg::STORE:  enc = rv_pkg::ENC_S;
      rv_pkg::OP:     enc = rv_pkg::ENC_R;
      rv_pkg::BRANCH: enc = rv_pkg::ENC_B;
      rv_pkg::JAL:    enc = rv_pkg::ENC_J;
      default:        enc = rv_pkg::ENC_NONE; // Unsupported, no side effects
    endcase
  end

  always_comb
  begin
    dec_d            = '0;
    dec_d.pc         = pc_i;
    dec_d.link_val   = link_val;
    dec_d.jal_target = jal_target;
    dec_d.alu_op     = rv_pkg::ALU_ADD;
    case (enc)
      rv_pkg::ENC_R:
      begin
        dec_d.rs1    = rs1;
        dec_d.rs2    = rs2;
        dec_d.rd     = rd;
        dec_d.alu_op = rv_pkg::alu_op_e'({instr_i[30], funct3});
      end
      rv_pkg::ENC_I:
      begin
        dec_d.rs1       = rs1;
        dec_d.rd        = rd;
        dec_d.imm       = imm_i;
        dec_d.imm_valid = 1'b1;
        if (opcode == rv_pkg::OP_IMM) // Bit 30 only selects SRAI
          dec_d.alu_op = rv_pkg::alu_op_e'({instr_i[30] & (funct3 == 3'b101), funct3});
        else if (opcode == rv_pkg::LOAD)
        begin
          dec_d.mem  = 1'b1;
          dec_d.size = funct3;
        end
        else
        begin
          dec_d.jalr = 1'b1;
          dec_d.link = 1'b1;
          dec_d.ret  = pop_c;
        end
      end
      rv_pkg::ENC_S:
      begin
        dec_d.rs1       = rs1;
        dec_d.rs2       = rs2;
        dec_d.imm       = imm_s;
        dec_d.imm_valid = 1'b1;
        dec_d.mem       = 1'b1;
        dec_d.mem_write = 1'b1;
        dec_d.size      = funct3;
      end
      rv_pkg::ENC_U:
      begin
        dec_d.rd        = rd;
        dec_d.imm       = (opcode == rv_pkg::LUI) ? imm_u : auipc_sum; // rs1 is x0
        dec_d.imm_valid = 1'b1;
      end
      rv_pkg::ENC_B:
      begin
        dec_d.rs1     = rs1;
        dec_d.rs2     = rs2;
        dec_d.imm     = imm_b; // Compare uses rs2
        dec_d.branch  = 1'b1;
        dec_d.br_cond = funct3;
      end
      rv_pkg::ENC_J:
      begin
        dec_d.rd   = rd;
        dec_d.jal  = 1'b1;
        dec_d.link = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      dec_o <= '0;
    else if (load_i)
      dec_o <= dec_d;
  end

endmodule

`default_nettype wire

// ==== src/rv_rf_if.sv ====
`default_nettype none

interface rv_rf_if #(
  parameter int XLEN = rv_pkg::XLEN_DEFAULT
);

  logic [rv_pkg::REG_BITS-1:0] rs1_addr;
  logic [rv_pkg::REG_BITS-1:0] rs2_addr;
  logic [XLEN-1:0]             rs1_data;
  logic [XLEN-1:0]             rs2_data;
  logic                        we;
  logic [rv_pkg::REG_BITS-1:0] waddr;
  logic [XLEN-1:0]             wdata;

  // Controller side reads at decode advance, writes at output handshake
  modport ctrl (
    output rs1_addr, rs2_addr, we, waddr, wdata,
    input  rs1_data, rs2_data
  );

  modport regfile (
    input  rs1_addr, rs2_addr, we, waddr, wdata,
    output rs1_data, rs2_data
  );

endinterface

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  localparam int XLEN_DEFAULT = 32;
  localparam int REG_BITS     = 5;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    LOAD   = 5'b00000,
    OP_IMM = 5'b00100,
    AUIPC  = 5'b00101,
    STORE  = 5'b01000,
    OP     = 5'b01100,
    LUI    = 5'b01101,
    BRANCH = 5'b11000,
    JALR   = 5'b11001,
    JAL    = 5'b11011
  } opcode_e;

  // {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  typedef enum logic [5:0] {
    ENC_NONE = 6'b000000,
    ENC_R    = 6'b000001, // Register-register
    ENC_I    = 6'b000010,
    ENC_S    = 6'b000100,
    ENC_U    = 6'b001000,
    ENC_B    = 6'b010000,
    ENC_J    = 6'b100000
  } enc_e;

  typedef struct packed {
    logic [REG_BITS-1:0]     rs1;     // Zero when unused
    logic [REG_BITS-1:0]     rs2;
    logic [REG_BITS-1:0]     rd;
    alu_op_e                 alu_op;
    logic [XLEN_DEFAULT-1:0] imm;
    logic                    imm_valid;
    logic                    branch;
    logic [2:0]              br_cond;
    logic                    jal;
    logic                    jalr;
    logic                    ret;     // Return, pops the stack
    logic                    link;
    logic [XLEN_DEFAULT-1:0] link_val;
    logic [XLEN_DEFAULT-1:0] jal_target;
    logic                    mem;
    logic                    mem_write;
    logic [2:0]              size;
    logic [XLEN_DEFAULT-1:0] pc;
  } decoded_t;

  typedef struct packed {
    logic [REG_BITS-1:0]     rd;
    logic [XLEN_DEFAULT-1:0] value;   // Address for memory ops
    logic                    redirect;
    logic [XLEN_DEFAULT-1:0] target;
    logic                    mem;
    logic                    write;
    logic [2:0]              size;
    logic [XLEN_DEFAULT-1:0] store_data;
    logic                    ret;
    logic                    pred_hit;
  } result_t;

endpackage

`default_nettype wire
